// ==== hdl/cnn_pkg.sv ====
package cnn_pkg;

    // image and kernel geometry
    localparam int IMG_DIM     = 6;
    localparam int KER_DIM     = 3;
    localparam int NUM_KERNELS = 2;
    localparam int MAP_DIM     = IMG_DIM - KER_DIM + 1;

    // 2x2 pooling over every map
    localparam int NUM_FEATURES = NUM_KERNELS * (MAP_DIM / 2) * (MAP_DIM / 2);
    localparam int NUM_CLASSES  = 4;

    // weight store layout with conv kernels first and fc rows after them
    localparam int CONV_WEIGHTS  = NUM_KERNELS * KER_DIM * KER_DIM;
    localparam int TOTAL_WEIGHTS = CONV_WEIGHTS + NUM_CLASSES * NUM_FEATURES;
    localparam int WADDR_W       = $clog2(TOTAL_WEIGHTS);

    typedef logic signed [7:0]  pixel_t;
    typedef logic signed [31:0] acc_t;

    // read request towards the weight store arbiter
    typedef struct packed {
        logic               valid;
        logic [WADDR_W-1:0] addr;
    } wt_req_t;

    // one convolution result with its map position
    typedef struct packed {
        logic [$clog2(NUM_KERNELS)-1:0] kernel;
        logic [$clog2(MAP_DIM)-1:0]     row;
        logic [$clog2(MAP_DIM)-1:0]     col;
        acc_t                           sum;
    } map_px_t;

    // pooled features indexed by kernel, pool row and pool column
    typedef pixel_t [NUM_FEATURES-1:0] feature_vec_t;

    typedef enum logic [1:0] {
        C_IDLE,
        C_LOAD,
        C_COMPUTE,
        C_EMIT
    } conv_state_t;

    typedef enum logic [1:0] {
        F_IDLE,
        F_COMPUTE,
        F_OUTPUT
    } fc_state_t;

endpackage

// ==== hdl/weight_store.sv ====
`timescale 1ns/1ps

module weight_store
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             weight_tvalid,
    output logic             weight_tready,
    input  cnn_pkg::pixel_t  weight_tdata,
    output logic             weights_loaded,
    input  cnn_pkg::wt_req_t conv_req,
    output logic             conv_grant,
    input  cnn_pkg::wt_req_t fc_req,
    output logic             fc_grant,
    output cnn_pkg::pixel_t  rd_data
);
    import cnn_pkg::*;

    pixel_t             mem [TOTAL_WEIGHTS];
    logic [WADDR_W-1:0] wr_cnt;
    logic [WADDR_W-1:0] rd_addr;
    logic               wr_fire;
    logic               conflict;
    logic               prio_fc;

    assign wr_fire = weight_tvalid && weight_tready;

    // round robin where prio_fc set means fc wins the next conflict
    assign conflict   = weights_loaded && conv_req.valid && fc_req.valid;
    assign conv_grant = weights_loaded && conv_req.valid && (!fc_req.valid || !prio_fc);
    assign fc_grant   = weights_loaded && fc_req.valid && (!conv_req.valid || prio_fc);
    assign rd_addr    = fc_grant ? fc_req.addr : conv_req.addr;

    // one pass of TOTAL_WEIGHTS after reset and then closed
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_cnt         <= '0;
            weights_loaded <= 1'b0;
            weight_tready  <= 1'b0;
        end
        else if (wr_fire)
        begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt == WADDR_W'(TOTAL_WEIGHTS - 1))
            begin
                weights_loaded <= 1'b1;
                weight_tready  <= 1'b0;
            end
        end
        else if (!weights_loaded)
        begin
            weight_tready <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            prio_fc <= 1'b0;
        else if (conflict)
            prio_fc <= !prio_fc;
    end

    // stored in arrival order; read data lands one cycle after the grant
    always_ff @(posedge clk)
    begin
        if (wr_fire)
            mem[wr_cnt] <= weight_tdata;
        if (conv_grant || fc_grant)
            rd_data <= mem[rd_addr];
    end

    // no engine asks for a weight before the store is filled
    assert property (@(posedge clk) disable iff (!resetn)
        !weights_loaded |-> !conv_req.valid && !fc_req.valid);

    // a waiting request keeps its address until it is granted
    assert property (@(posedge clk) disable iff (!resetn)
        conv_req.valid && !conv_grant |=> conv_req.valid && $stable(conv_req.addr));

    assert property (@(posedge clk) disable iff (!resetn)
        fc_req.valid && !fc_grant |=> fc_req.valid && $stable(fc_req.addr));

    // the loser of a conflict is served in the very next cycle
    assert property (@(posedge clk) disable iff (!resetn)
        conflict && fc_grant |=> conv_grant);

    assert property (@(posedge clk) disable iff (!resetn)
        conflict && conv_grant |=> fc_grant);

endmodule

// ==== hdl/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             weights_loaded,
    input  logic             image_tvalid,
    output logic             image_tready,
    input  cnn_pkg::pixel_t  image_tdata,
    output cnn_pkg::wt_req_t wt_req,
    input  logic             wt_grant,
    input  cnn_pkg::pixel_t  wt_data,
    output cnn_pkg::map_px_t map_px,
    output logic             map_valid,
    input  logic             map_ready
);
    import cnn_pkg::*;

    localparam int PIX_AW  = $clog2(IMG_DIM * IMG_DIM);
    localparam int TAP_MAX = KER_DIM - 1;
    localparam int POS_MAX = MAP_DIM - 1;

    conv_state_t       state;
    pixel_t            img [IMG_DIM * IMG_DIM];
    logic [PIX_AW-1:0] pix_cnt;
    logic [PIX_AW-1:0] px_idx;
    logic              kern;
    logic [1:0]        row;
    logic [1:0]        col;
    logic [1:0]        kr;
    logic [1:0]        kc;
    logic              mac_en;
    pixel_t            pix_d;
    acc_t              acc;
    acc_t              sum_now;
    logic              img_fire;
    logic              load_done;
    logic              last_tap;
    logic              last_px;
    logic              emit;
    logic              clear_acc;

    assign image_tready = weights_loaded && (state == C_IDLE || state == C_LOAD);
    assign img_fire     = image_tvalid && image_tready;
    assign load_done    = img_fire && (pix_cnt == PIX_AW'(IMG_DIM * IMG_DIM - 1));

    assign last_tap  = (kr == TAP_MAX) && (kc == TAP_MAX);
    assign last_px   = kern && (row == POS_MAX) && (col == POS_MAX);
    assign emit      = (state == C_EMIT) && map_ready;
    assign clear_acc = load_done || (emit && !last_px);

    // image pixel under the current tap in the row-major buffer
    assign px_idx = PIX_AW'((row + kr) * IMG_DIM + (col + kc));

    assign wt_req.valid = (state == C_COMPUTE);
    assign wt_req.addr  = WADDR_W'(kern * KER_DIM * KER_DIM + kr * KER_DIM + kc);

    // last product is folded in on the emit cycle itself
    assign sum_now   = mac_en ? acc + wt_data * pix_d : acc;
    assign map_px    = '{kernel: kern, row: row, col: col, sum: sum_now};
    assign map_valid = emit;

    always_ff @(posedge clk)
    begin
        if (img_fire)
            img[pix_cnt] <= image_tdata;
        if (wt_grant)
            pix_d <= img[px_idx];
        if (clear_acc)
            acc <= '0;
        else if (mac_en)
            acc <= sum_now;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state   <= C_IDLE;
            pix_cnt <= '0;
            kern    <= 1'b0;
            row     <= '0;
            col     <= '0;
            kr      <= '0;
            kc      <= '0;
            mac_en  <= 1'b0;
        end
        else
        begin
            mac_en <= wt_grant;
            case (state)
                C_IDLE, C_LOAD:
                begin
                    if (img_fire)
                    begin
                        pix_cnt <= pix_cnt + 1'b1;
                        state   <= C_LOAD;
                    end
                    if (load_done)
                    begin
                        pix_cnt           <= '0;
                        {kern, row, col}  <= '0;
                        {kr, kc}          <= '0;
                        state             <= C_COMPUTE;
                    end
                end
                C_COMPUTE:
                begin
                    // walk the 3x3 taps one per granted read
                    if (wt_grant)
                    begin
                        if (kc == TAP_MAX)
                        begin
                            kc <= '0;
                            kr <= (kr == TAP_MAX) ? 2'd0 : kr + 1'b1;
                        end
                        else
                        begin
                            kc <= kc + 1'b1;
                        end
                        if (last_tap)
                            state <= C_EMIT;
                    end
                end
                C_EMIT:
                begin
                    if (emit)
                    begin
                        // map sides are powers of two so one counter spans kernel, row and col
                        {kern, row, col} <= {kern, row, col} + 1'b1;
                        state            <= last_px ? C_IDLE : C_COMPUTE;
                    end
                end
                default:
                begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    // a grant outside a pending read would corrupt the accumulator
    assert property (@(posedge clk) disable iff (!resetn)
        wt_grant |-> wt_req.valid);

endmodule

// ==== hdl/relu_pool.sv ====
`timescale 1ns/1ps

module relu_pool
#(
    parameter int RELU_SHIFT = 4
)
(
    input  logic                  clk,
    input  logic                  resetn,
    input  cnn_pkg::map_px_t      map_px,
    input  logic                  map_valid,
    output logic                  map_ready,
    output cnn_pkg::feature_vec_t feat,
    output logic                  feat_valid,
    input  logic                  feat_ready
);
    import cnn_pkg::*;

    localparam acc_t SAT_MAX = 127;

    acc_t                            shifted;
    pixel_t                          relu_val;
    logic [$clog2(NUM_FEATURES)-1:0] win;
    logic                            first_px;
    logic                            last_px;
    feature_vec_t                    work;
    feature_vec_t                    work_nxt;

    // clamp, requantize, saturate
    assign shifted = map_px.sum >>> RELU_SHIFT;

    always_comb
    begin
        if (map_px.sum < 0)
            relu_val = '0;
        else if (shifted > SAT_MAX)
            relu_val = pixel_t'(SAT_MAX);
        else
            relu_val = pixel_t'(shifted);
    end

    // pool window from kernel and halved row/col
    assign win      = {map_px.kernel, map_px.row[1], map_px.col[1]};
    assign first_px = !map_px.row[0] && !map_px.col[0];
    assign last_px  = map_px.kernel && (&map_px.row) && (&map_px.col);

    always_comb
    begin
        work_nxt = work;
        if (first_px || relu_val > work[win])
            work_nxt[win] = relu_val;
    end

    // stall conv only when a held vector cannot leave this cycle
    assign map_ready = !feat_valid || feat_ready;

    always_ff @(posedge clk)
    begin
        if (map_valid)
            work <= work_nxt;
        if (map_valid && last_px)
            feat <= work_nxt;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            feat_valid <= 1'b0;
        else if (map_valid && last_px)
            feat_valid <= 1'b1;
        else if (feat_ready)
            feat_valid <= 1'b0;
    end

endmodule

// ==== hdl/fc_engine.sv ====
`timescale 1ns/1ps

module fc_engine
(
    input  logic                  clk,
    input  logic                  resetn,
    input  cnn_pkg::feature_vec_t feat,
    input  logic                  feat_valid,
    output logic                  feat_ready,
    output cnn_pkg::wt_req_t      wt_req,
    input  logic                  wt_grant,
    input  cnn_pkg::pixel_t       wt_data,
    output logic                  result_tvalid,
    input  logic                  result_tready,
    output cnn_pkg::acc_t         result_tdata,
    output logic                  result_tlast
);
    import cnn_pkg::*;

    localparam int FEAT_AW  = $clog2(NUM_FEATURES);
    localparam int CLASS_AW = $clog2(NUM_CLASSES);

    fc_state_t           state;
    feature_vec_t        feat_q;
    logic [CLASS_AW-1:0] cls;
    logic [FEAT_AW-1:0]  fidx;
    logic                mac_en;
    pixel_t              feat_d;
    acc_t                acc;
    acc_t                sum_now;
    logic                accept;
    logic                out_fire;
    logic                last_cls;

    assign feat_ready = (state == F_IDLE);
    assign accept     = feat_valid && feat_ready;
    assign out_fire   = result_tvalid && result_tready;
    assign last_cls   = (cls == CLASS_AW'(NUM_CLASSES - 1));

    // row of fc weights for this class sits after the conv kernels
    assign wt_req.valid = (state == F_COMPUTE);
    assign wt_req.addr  = WADDR_W'(CONV_WEIGHTS + cls * NUM_FEATURES + fidx);

    assign sum_now       = mac_en ? acc + wt_data * feat_d : acc;
    assign result_tvalid = (state == F_OUTPUT);
    assign result_tdata  = sum_now;
    assign result_tlast  = result_tvalid && last_cls;

    always_ff @(posedge clk)
    begin
        if (accept)
            feat_q <= feat;
        if (wt_grant)
            feat_d <= feat_q[fidx];
        if (accept || (out_fire && !last_cls))
            acc <= '0;
        else if (mac_en)
            acc <= sum_now;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state  <= F_IDLE;
            cls    <= '0;
            fidx   <= '0;
            mac_en <= 1'b0;
        end
        else
        begin
            mac_en <= wt_grant;
            case (state)
                F_IDLE:
                begin
                    if (accept)
                    begin
                        cls   <= '0;
                        fidx  <= '0;
                        state <= F_COMPUTE;
                    end
                end
                F_COMPUTE:
                begin
                    // fidx wraps back to zero after the last feature
                    if (wt_grant)
                    begin
                        fidx <= fidx + 1'b1;
                        if (fidx == FEAT_AW'(NUM_FEATURES - 1))
                            state <= F_OUTPUT;
                    end
                end
                F_OUTPUT:
                begin
                    if (out_fire)
                    begin
                        cls   <= cls + 1'b1;
                        state <= last_cls ? F_IDLE : F_COMPUTE;
                    end
                end
                default:
                begin
                    state <= F_IDLE;
                end
            endcase
        end
    end

    // held result must not move under back-pressure
    assert property (@(posedge clk) disable iff (!resetn)
        result_tvalid && !result_tready |=> result_tvalid && $stable(result_tdata));

endmodule

// ==== hdl/cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top
#(
    parameter int RELU_SHIFT = 4
)
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            weight_tvalid,
    output logic            weight_tready,
    input  cnn_pkg::pixel_t weight_tdata,
    input  logic            image_tvalid,
    output logic            image_tready,
    input  cnn_pkg::pixel_t image_tdata,
    output logic            result_tvalid,
    input  logic            result_tready,
    output cnn_pkg::acc_t   result_tdata,
    output logic            result_tlast
);
    import cnn_pkg::*;

    logic         weights_loaded;
    wt_req_t      conv_req;
    wt_req_t      fc_req;
    logic         conv_grant;
    logic         fc_grant;
    pixel_t       rd_data;
    map_px_t      map_px;
    logic         map_valid;
    logic         map_ready;
    feature_vec_t feat;
    logic         feat_valid;
    logic         feat_ready;

    weight_store u_weight_store (
        .clk            (clk),
        .resetn         (resetn),
        .weight_tvalid  (weight_tvalid),
        .weight_tready  (weight_tready),
        .weight_tdata   (weight_tdata),
        .weights_loaded (weights_loaded),
        .conv_req       (conv_req),
        .conv_grant     (conv_grant),
        .fc_req         (fc_req),
        .fc_grant       (fc_grant),
        .rd_data        (rd_data)
    );

    conv_engine u_conv_engine (
        .clk            (clk),
        .resetn         (resetn),
        .weights_loaded (weights_loaded),
        .image_tvalid   (image_tvalid),
        .image_tready   (image_tready),
        .image_tdata    (image_tdata),
        .wt_req         (conv_req),
        .wt_grant       (conv_grant),
        .wt_data        (rd_data),
        .map_px         (map_px),
        .map_valid      (map_valid),
        .map_ready      (map_ready)
    );

    relu_pool #(
        .RELU_SHIFT (RELU_SHIFT)
    ) u_relu_pool (
        .clk        (clk),
        .resetn     (resetn),
        .map_px     (map_px),
        .map_valid  (map_valid),
        .map_ready  (map_ready),
        .feat       (feat),
        .feat_valid (feat_valid),
        .feat_ready (feat_ready)
    );

    fc_engine u_fc_engine (
        .clk           (clk),
        .resetn        (resetn),
        .feat          (feat),
        .feat_valid    (feat_valid),
        .feat_ready    (feat_ready),
        .wt_req        (fc_req),
        .wt_grant      (fc_grant),
        .wt_data       (rd_data),
        .result_tvalid (result_tvalid),
        .result_tready (result_tready),
        .result_tdata  (result_tdata),
        .result_tlast  (result_tlast)
    );

endmodule

// ==== testbench/tb_cnn.sv ====
`timescale 1ns/1ps

module tb_cnn;
    import cnn_pkg::*;

    localparam int NUM_IMAGES = 2;
    localparam int IMG_PIXELS = IMG_DIM * IMG_DIM;
    localparam int IMG_BASE   = TOTAL_WEIGHTS;
    localparam int EXP_BASE   = IMG_BASE + NUM_IMAGES * IMG_PIXELS;
    localparam int NUM_RES    = NUM_IMAGES * NUM_CLASSES;
    localparam int STIM_WORDS = EXP_BASE + NUM_RES;
    localparam int TIMEOUT    = 5000;
    localparam int DRAIN      = 20;

    logic        clk;
    logic        resetn;
    logic        weight_tvalid;
    logic        weight_tready;
    pixel_t      weight_tdata;
    logic        image_tvalid;
    logic        image_tready;
    pixel_t      image_tdata;
    logic        result_tvalid;
    logic        result_tready;
    acc_t        result_tdata;
    logic        result_tlast;

    logic [31:0] stim [STIM_WORDS];
    logic [31:0] lfsr;
    int          weights_sent;
    logic        run_done;

    cnn_top #(
        .RELU_SHIFT (4)
    ) DUT (
        .clk           (clk),
        .resetn        (resetn),
        .weight_tvalid (weight_tvalid),
        .weight_tready (weight_tready),
        .weight_tdata  (weight_tdata),
        .image_tvalid  (image_tvalid),
        .image_tready  (image_tready),
        .image_tdata   (image_tdata),
        .result_tvalid (result_tvalid),
        .result_tready (result_tready),
        .result_tdata  (result_tdata),
        .result_tlast  (result_tlast)
    );

    always #10 clk = ~clk;

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic send_weights;
        int waited;
        for (int i = 0; i < TOTAL_WEIGHTS; i++)
        begin
            weight_tvalid = 1'b1;
            weight_tdata  = pixel_t'(stim[i][7:0]);
            waited        = 0;
            @(negedge clk);
            while (!weight_tready)
            begin
                waited++;
                if (waited > TIMEOUT)
                    abort_run($sformatf("weight %0d was never accepted", i));
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            weights_sent++;
        end
        // offer one more byte that the store must refuse from now on
        weight_tdata = 8'h55;
        waited       = 0;
        while (!run_done)
        begin
            @(negedge clk);
            check("weight_tready after load", 0, weight_tready);
            waited++;
            if (waited > 4 * TIMEOUT)
                abort_run("run did not finish while watching the weight stream");
        end
        @(posedge clk);
        #2;
        weight_tvalid = 1'b0;
    endtask

    task automatic send_images;
        int waited;
        for (int i = 0; i < NUM_IMAGES * IMG_PIXELS; i++)
        begin
            image_tvalid = 1'b1;
            image_tdata  = pixel_t'(stim[IMG_BASE + i][7:0]);
            waited       = 0;
            @(negedge clk);
            while (!image_tready)
            begin
                waited++;
                if (waited > TIMEOUT)
                    abort_run($sformatf("image pixel %0d was never accepted", i));
                @(negedge clk);
            end
            if (i == 0)
                check("image_tready low until weights loaded", TOTAL_WEIGHTS, weights_sent);
            @(posedge clk);
            #2;
        end
        image_tvalid = 1'b0;
    endtask

    task automatic collect_results;
        int   n;
        int   waited;
        logic held;
        acc_t hold_data;
        n      = 0;
        waited = 0;
        held   = 1'b0;
        while (n < NUM_RES)
        begin
            @(posedge clk);
            #2;
            lfsr          = lfsr_step(lfsr);
            result_tready = lfsr[0];
            @(negedge clk);
            waited++;
            if (held)
            begin
                check("result_tvalid under back-pressure", 1, result_tvalid);
                check("result_tdata under back-pressure", hold_data, result_tdata);
            end
            if (result_tvalid && result_tready)
            begin
                check($sformatf("result %0d", n), stim[EXP_BASE + n], result_tdata);
                check($sformatf("result_tlast %0d", n), (n % NUM_CLASSES) == NUM_CLASSES - 1,
                      result_tlast);
                n++;
                waited = 0;
                held   = 1'b0;
            end
            else if (result_tvalid)
            begin
                held      = 1'b1;
                hold_data = result_tdata;
            end
            if (waited > TIMEOUT)
                abort_run($sformatf("result %0d did not arrive", n));
        end
        // nothing may follow the last result
        @(posedge clk);
        #2;
        result_tready = 1'b1;
        for (int i = 0; i < DRAIN; i++)
        begin
            @(negedge clk);
            check("result_tvalid after last result", 0, result_tvalid);
        end
        run_done = 1'b1;
    endtask

    initial
    begin
        clk           = 1'b0;
        resetn        = 1'b0;
        weight_tvalid = 1'b0;
        weight_tdata  = '0;
        image_tvalid  = 1'b0;
        image_tdata   = '0;
        result_tready = 1'b0;
        weights_sent  = 0;
        run_done      = 1'b0;
        lfsr          = 32'hd3da;
        $readmemh("testbench/cnn_stimulus.txt", stim);
        if ($isunknown(stim[STIM_WORDS - 1]))
            abort_run("stimulus file is missing or too short");
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;
        fork
            send_weights();
            send_images();
            collect_results();
        join
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/cnn_pkg.sv
hdl/weight_store.sv
hdl/conv_engine.sv
hdl/relu_pool.sv
hdl/fc_engine.sv
hdl/cnn_top.sv
testbench/tb_cnn.sv

// ==== testbench/cnn_stimulus.txt ====
// hex words: 50 weights (kernel 0 and 1 row by row, then fc rows for class 0..3),
// then two 6x6 images row by row, then 8 expected 32-bit results in output order
// kernel 0, all ones
01 01 01
01 01 01
01 01 01
// kernel 1, vertical gradient
f0 e0 f0
00 00 00
10 20 10
// fc class 0
01 01 01 01 01 01 01 01
// fc class 1
01 ff 02 fe 00 00 01 ff
// fc class 2
fd 00 00 00 02 00 00 00
// fc class 3
9c 32 19 f4 40 c0 7f 80
// image 0, pixel = 6*row + col
00 01 02 03 04 05
06 07 08 09 0a 0b
0c 0d 0e 0f 10 11
12 13 14 15 16 17
18 19 1a 1b 1c 1d
1e 1f 20 21 22 23
// image 1, pixel = 20*row - 10*col
00 f6 ec e2 d8 ce
14 0a 00 f6 ec e2
28 1e 14 0a 00 f6
3c 32 28 1e 14 0a
50 46 3c 32 28 1e
64 5a 50 46 3c 32
// image 0 features 7 9 14 15 48 48 48 48
000000ed fffffffc 0000004b ffffff80
// image 1 features 16 5 39 28 127 127 127 127
00000254 00000021 000000ce fffffcba
